//--- rtl/mmio_afu_config.svh
`ifndef MMIO_AFU_CONFIG_SVH
`define MMIO_AFU_CONFIG_SVH

// Width of the word address on the slave port
// One address step is one 512-bit word, so 64 bytes
// Any value from 6 to 26 keeps the byte address within 32 bits
`define MMIO_ADDR_WIDTH 16

// 128-bit identifier returned in lanes 1 and 2 of word 0
// Lane 1 carries the low half and lane 2 the high half
`define MMIO_AFU_ID 128'h5a3c_91e2_7b04_4d6f_a81c_2e95_07d3_b64f

// Clock frequency in MHz as reported in bits 31:16 of the status word
// The field is 16 bits wide, so keep the value below 65536
`define MMIO_CLOCK_FREQ_MHZ 16'd250

// Host software only reads these values back
// Nothing in the datapath depends on the identifier or the frequency
// Changing them moves no timing and no register index

`endif

//--- rtl/mmio_afu_pkg.sv
`include "mmio_afu_config.svh"

package mmio_afu_pkg;

    // ======================================================================
    // Width types shared by the endpoint blocks
    // ======================================================================

    // Word address, one step per 64-byte word
    typedef logic [`MMIO_ADDR_WIDTH-1:0] mmio_addr_t;

    // Full data word, eight 64-bit lanes with lane 0 in the low bits
    typedef logic [7:0][63:0] mmio_data_t;

    // One enable bit per byte of the data word
    typedef logic [63:0] mmio_mask_t;

    // Byte offset inside one 64-byte word
    typedef logic [5:0] byte_idx_t;

    // Register index, taken from the low bits of the word address
    typedef logic [11:0] csr_idx_t;

    // A single 64-bit register value
    typedef logic [63:0] word64_t;

    // ======================================================================
    // Byte enable decoding
    // ======================================================================

    // Position of the lowest set bit in a byte enable
    // Returns 64 when no byte is enabled, so the result needs 7 bits
    // Scanning from the top lets the last hit win, which is the lowest bit
    function automatic logic [6:0] first_enabled_byte(mmio_mask_t mask);
        logic [6:0] idx;
        idx = 7'd64;
        for (int i = 63; i >= 0; i--)
        begin
            if (mask[i])
            begin
                idx = 7'(i);
            end
        end
        return idx;
    endfunction

endpackage

//--- rtl/mmio_wait_throttle.sv
module mmio_wait_throttle
(
    input  logic clk,
    input  logic reset_n,
    output logic waitrequest
);

    // ======================================================================
    // Rotating stall pattern
    // ======================================================================

    // Sixteen-bit ring with a single zero in it
    // The zero walks one place to the left on every clock edge
    logic [15:0] wait_ring;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            // Zero starts in bit 0, every other bit stalls the master
            wait_ring <= {{15{1'b1}}, 1'b0};
        end
        else
        begin
            // Left rotate, bit 15 wraps back into bit 0
            wait_ring <= {wait_ring[14:0], wait_ring[15]};
        end
    end

    // Bit 8 is the tap that stalls the port
    // While reset holds the ring, bit 8 stays high
    // After release the zero needs eight edges to reach the tap
    // and then comes back once every sixteen cycles
    assign waitrequest = wait_ring[8];

endmodule

//--- rtl/mmio_write_capture.sv
module mmio_write_capture
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    write,
    input  logic                    waitrequest,
    input  mmio_afu_pkg::mmio_addr_t address,
    input  mmio_afu_pkg::mmio_data_t writedata,
    input  mmio_afu_pkg::mmio_mask_t byteenable,
    output mmio_afu_pkg::mmio_data_t wr_data,
    output mmio_afu_pkg::mmio_mask_t wr_mask,
    output mmio_afu_pkg::mmio_addr_t wr_addr,
    output mmio_afu_pkg::byte_idx_t  wr_byte_idx
);

    // ======================================================================
    // Write acceptance
    // ======================================================================

    // A write is taken on the edge where the master drives write
    // and the throttle has waitrequest low
    logic write_accept;

    assign write_accept = write && !waitrequest;

    // Offset of the first enabled byte of the incoming write
    // The decoder gives 64 for an empty mask, which wraps to offset 0
    // once only the low six bits are kept
    mmio_afu_pkg::byte_idx_t write_byte_idx;

    assign write_byte_idx = mmio_afu_pkg::byte_idx_t'(
        mmio_afu_pkg::first_enabled_byte(byteenable));

    // ======================================================================
    // Last-write registers
    // ======================================================================

    // These hold the most recent accepted write for read-back
    // A read accepted on any later edge sees the new values
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            // All ones marks that no write has happened since reset
            wr_data     <= '1;
            wr_mask     <= '1;
            wr_addr     <= '1;
            wr_byte_idx <= '1;
        end
        else if (write_accept)
        begin
            wr_data     <= writedata;
            wr_mask     <= byteenable;
            wr_addr     <= address;
            wr_byte_idx <= write_byte_idx;
        end
    end

endmodule

//--- rtl/mmio_read_responder.sv
`include "mmio_afu_config.svh"

module mmio_read_responder
(
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     read,
    input  logic                     waitrequest,
    input  mmio_afu_pkg::mmio_addr_t address,
    input  mmio_afu_pkg::mmio_mask_t byteenable,
    input  mmio_afu_pkg::mmio_data_t wr_data,
    input  mmio_afu_pkg::mmio_mask_t wr_mask,
    input  mmio_afu_pkg::mmio_addr_t wr_addr,
    input  mmio_afu_pkg::byte_idx_t  wr_byte_idx,
    output mmio_afu_pkg::mmio_data_t readdata,
    output logic                     readdatavalid
);

    // ======================================================================
    // Stage one: capture the request and build the identity block
    // ======================================================================

    // Valid bit and register index of the read in flight
    logic                   read_req_q;
    mmio_afu_pkg::csr_idx_t read_idx_q;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            read_req_q <= 1'b0;
        end
        else
        begin
            read_req_q <= read && !waitrequest;
        end
    end

    // The index is sampled every cycle and only matters when read_req_q is set
    always_ff @(posedge clk)
    begin
        read_idx_q <= mmio_afu_pkg::csr_idx_t'(address);
    end

    // Byte address of the current request
    // Word address on top, offset of the first enabled byte below it
    logic [31:0] req_byte_addr;

    assign req_byte_addr = 32'({address, mmio_afu_pkg::byte_idx_t'(
        mmio_afu_pkg::first_enabled_byte(byteenable))});

    // Word 0 contents, registered so the second stage only has to select
    mmio_afu_pkg::mmio_data_t ident_q;

    always_ff @(posedge clk)
    begin
        ident_q <= '0;
        // Device feature header with feature type 1
        ident_q[0][63:60] <= 4'h1;
        // This endpoint is the last entry of the feature list
        ident_q[0][40] <= 1'b1;
        // Identifier split across two lanes
        ident_q[1] <= mmio_afu_pkg::word64_t'(`MMIO_AFU_ID);
        ident_q[2] <= mmio_afu_pkg::word64_t'(`MMIO_AFU_ID >> 64);
        // Byte address in both halves, so a 32-bit read of either half sees it
        ident_q[7] <= {req_byte_addr, req_byte_addr};
    end

    // ======================================================================
    // Stage two: register map
    // ======================================================================

    // Status word
    // Bits 15:14 at 3 report the 512-bit data path,
    // the low nibble at 0 reports an Avalon-style port
    mmio_afu_pkg::word64_t status_word;

    assign status_word = {32'h0, 16'(`MMIO_CLOCK_FREQ_MHZ), 2'h3, 14'h0};

    // Byte address of the last write, zero-extended into one lane
    mmio_afu_pkg::word64_t wr_byte_addr;

    assign wr_byte_addr = mmio_afu_pkg::word64_t'({wr_addr, wr_byte_idx});

    // Eight mask bits of the 64-bit lane holding the first written byte
    mmio_afu_pkg::word64_t wr_lane_mask;

    assign wr_lane_mask = mmio_afu_pkg::word64_t'(wr_mask[{wr_byte_idx[5:3], 3'b000} +: 8]);

    mmio_afu_pkg::mmio_data_t reply;

    always_comb
    begin
        reply = '0;
        case (read_idx_q)
            // Feature header, identifier and address echo
            12'h000: reply = ident_q;
            // Status register in lane 0
            12'h002: reply[0] = status_word;
            // Write data, as seen through the 64-bit and the 512-bit view
            12'h004,
            12'h008: reply = wr_data;
            // 64-bit view of address and mask
            12'h006:
            begin
                reply[0] = wr_byte_addr;
                reply[1] = wr_lane_mask;
            end
            // 512-bit view of address and mask
            12'h00a:
            begin
                reply[0] = wr_byte_addr;
                reply[1] = wr_mask;
            end
            // Unmapped indexes read as zero
            default: reply = '0;
        endcase
    end

    // Valid is control state, the data lanes are plain payload
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            readdatavalid <= 1'b0;
        end
        else
        begin
            readdatavalid <= read_req_q;
        end
    end

    always_ff @(posedge clk)
    begin
        readdata <= reply;
    end

endmodule

//--- rtl/mmio_test_afu.sv
module mmio_test_afu
(
    input  logic                     clk,
    input  logic                     reset_n,
    input  mmio_afu_pkg::mmio_addr_t address,
    input  logic                     read,
    input  logic                     write,
    input  mmio_afu_pkg::mmio_data_t writedata,
    input  mmio_afu_pkg::mmio_mask_t byteenable,
    output logic                     waitrequest,
    output mmio_afu_pkg::mmio_data_t readdata,
    output logic                     readdatavalid
);

    // ======================================================================
    // Internal wiring
    // ======================================================================

    // Last accepted write, passed from the capture block to the responder
    mmio_afu_pkg::mmio_data_t wr_data;
    mmio_afu_pkg::mmio_mask_t wr_mask;
    mmio_afu_pkg::mmio_addr_t wr_addr;
    mmio_afu_pkg::byte_idx_t  wr_byte_idx;

    // ======================================================================
    // Blocks
    // ======================================================================

    // Stall generator, its output goes to the port and to both other blocks
    mmio_wait_throttle u_wait_throttle
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .waitrequest (waitrequest)
    );

    // Holds the most recent accepted write
    mmio_write_capture u_write_capture
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .write       (write),
        .waitrequest (waitrequest),
        .address     (address),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .wr_data     (wr_data),
        .wr_mask     (wr_mask),
        .wr_addr     (wr_addr),
        .wr_byte_idx (wr_byte_idx)
    );

    // Answers reads one edge after acceptance
    mmio_read_responder u_read_responder
    (
        .clk           (clk),
        .reset_n       (reset_n),
        .read          (read),
        .waitrequest   (waitrequest),
        .address       (address),
        .byteenable    (byteenable),
        .wr_data       (wr_data),
        .wr_mask       (wr_mask),
        .wr_addr       (wr_addr),
        .wr_byte_idx   (wr_byte_idx),
        .readdata      (readdata),
        .readdatavalid (readdatavalid)
    );

endmodule

//--- testbench/mmio_test_afu_checker.sv
module mmio_test_afu_checker
(
    input logic clk,
    input logic reset_n,
    input logic read,
    input logic waitrequest,
    input logic readdatavalid
);

    timeunit 1ns;
    timeprecision 1ps;

    // Number of failed assertions, read by the testbench at the end of the run
    int assert_errors = 0;

    // ======================================================================
    // Read response timing
    // ======================================================================

    // A read accepted at edge N shows readdatavalid after edge N+1
    // Sampled at the clock, the valid beat is seen two edges after acceptance
    valid_after_accept: assert property (@(posedge clk) disable iff (!reset_n)
        readdatavalid |-> $past(read && !waitrequest, 2))
    else
    begin
        $error("readdatavalid without a read accepted one edge before it");
        assert_errors++;
    end

    // ======================================================================
    // Throttle pattern
    // ======================================================================

    // The ring holds a single zero, so a low cycle is always followed by a stall
    single_low_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        !waitrequest |=> waitrequest)
    else
    begin
        $error("waitrequest was low on two consecutive cycles");
        assert_errors++;
    end

    // Once the ring has been loaded in reset, the tap must stall the master
    // The first edge is skipped because the ring is loaded on it
    wait_in_reset: assert property (@(posedge clk)
        (!reset_n && $past(!reset_n)) |-> waitrequest)
    else
    begin
        $error("waitrequest was low while reset_n was low");
        assert_errors++;
    end

endmodule

bind mmio_test_afu mmio_test_afu_checker u_checker
(
    .clk           (clk),
    .reset_n       (reset_n),
    .read          (read),
    .waitrequest   (waitrequest),
    .readdatavalid (readdatavalid)
);

//--- testbench/mmio_test_afu_tb.sv
`include "mmio_afu_config.svh"

module mmio_test_afu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // ======================================================================
    // Test sizes and run limit
    // ======================================================================

    localparam int N_IDENT    = 8;
    localparam int N_UNMAPPED = 8;
    localparam int N_WRITES   = 6;
    localparam int N_B2B      = 3;
    // Every write in test 5 is followed by four reads
    localparam int NUM_REQUESTS = N_IDENT + 1 + N_UNMAPPED + 4 + N_WRITES * 5 + N_B2B * 2;
    // Each request waits at most 16 cycles for the throttle plus a short tail
    localparam int CYCLE_LIMIT  = NUM_REQUESTS * 32 + 200;

    logic                     clk;
    logic                     reset_n;
    mmio_afu_pkg::mmio_addr_t address;
    logic                     read;
    logic                     write;
    mmio_afu_pkg::mmio_data_t writedata;
    mmio_afu_pkg::mmio_mask_t byteenable;
    logic                     waitrequest;
    mmio_afu_pkg::mmio_data_t readdata;
    logic                     readdatavalid;

    logic [63:0] lcg_state;
    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;

    // Model of the last accepted write, all ones until the first write
    mmio_afu_pkg::mmio_data_t model_data;
    mmio_afu_pkg::mmio_mask_t model_mask;
    mmio_afu_pkg::mmio_addr_t model_addr;
    mmio_afu_pkg::byte_idx_t  model_byte_idx;

    // Reads that were accepted and still wait for their data beat
    mmio_afu_pkg::mmio_data_t exp_data_q[$];
    int                       exp_cycle_q[$];
    logic                     read_pending;
    mmio_afu_pkg::mmio_data_t mon_data;
    int                       mon_cycle;

    mmio_test_afu dut
    (
        .clk           (clk),
        .reset_n       (reset_n),
        .address       (address),
        .read          (read),
        .write         (write),
        .writedata     (writedata),
        .byteenable    (byteenable),
        .waitrequest   (waitrequest),
        .readdata      (readdata),
        .readdatavalid (readdatavalid)
    );

    always #20 clk = ~clk;

    // ======================================================================
    // Random numbers and the reference model
    // ======================================================================

    // 64-bit LCG, the upper half has the best statistics
    function automatic logic [31:0] lcg_rand32();
        lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcg_state[63:32];
    endfunction

    function automatic mmio_afu_pkg::mmio_data_t random_data();
        logic [511:0] bits;
        for (int i = 0; i < 16; i++)
        begin
            bits[32*i +: 32] = lcg_rand32();
        end
        return bits;
    endfunction

    // The shift moves the lowest enabled byte across the whole word
    function automatic mmio_afu_pkg::mmio_mask_t random_byte_enable();
        logic [63:0] bits;
        bits = {lcg_rand32(), lcg_rand32()};
        return bits << (lcg_rand32() % 64);
    endfunction

    // Word address with the given register index and random upper bits
    function automatic mmio_afu_pkg::mmio_addr_t index_addr(mmio_afu_pkg::csr_idx_t idx);
        return mmio_afu_pkg::mmio_addr_t'((lcg_rand32() & 32'hffff_f000) | 32'(idx));
    endfunction

    // Half odd indexes inside the map, half indexes above it
    function automatic mmio_afu_pkg::csr_idx_t unmapped_index();
        logic [31:0] r;
        r = lcg_rand32();
        if (r[31])
        begin
            return mmio_afu_pkg::csr_idx_t'(2 * (r % 6) + 1);
        end
        return mmio_afu_pkg::csr_idx_t'(12 + r % 4084);
    endfunction

    // Scan upward for the first enabled byte
    // An empty mask gives 64, which is offset 0 in six bits
    function automatic mmio_afu_pkg::byte_idx_t lowest_enabled_byte(mmio_afu_pkg::mmio_mask_t be);
        int pos;
        pos = 0;
        while (pos < 64 && !be[pos])
        begin
            pos++;
        end
        return mmio_afu_pkg::byte_idx_t'(pos % 64);
    endfunction

    function automatic mmio_afu_pkg::mmio_data_t expected_read(
        mmio_afu_pkg::mmio_addr_t addr,
        mmio_afu_pkg::mmio_mask_t be,
        mmio_afu_pkg::mmio_data_t m_data,
        mmio_afu_pkg::mmio_mask_t m_mask,
        mmio_afu_pkg::mmio_addr_t m_addr,
        mmio_afu_pkg::byte_idx_t  m_byte_idx
    );
        mmio_afu_pkg::mmio_data_t rsp;
        mmio_afu_pkg::csr_idx_t   idx;
        logic [127:0]             afu_id;
        logic [31:0]              req_addr;
        mmio_afu_pkg::word64_t    wr_addr64;
        rsp       = '0;
        idx       = mmio_afu_pkg::csr_idx_t'(addr);
        afu_id    = `MMIO_AFU_ID;
        // Byte address is the word address times 64 plus the byte offset
        req_addr  = 32'(addr) * 32'd64 + 32'(lowest_enabled_byte(be));
        wr_addr64 = 64'(m_addr) * 64'd64 + 64'(m_byte_idx);
        case (idx)
            12'd0:
            begin
                // Feature type 1 in the top nibble and end-of-list in bit 40
                rsp[0] = 64'h1000_0100_0000_0000;
                rsp[1] = afu_id[63:0];
                rsp[2] = afu_id[127:64];
                rsp[7] = {req_addr, req_addr};
            end
            12'd2:
            begin
                // Frequency field and the two data path bits, the rest stays zero
                rsp[0][31:16] = `MMIO_CLOCK_FREQ_MHZ;
                rsp[0][15:14] = 2'b11;
            end
            12'd4,
            12'd8: rsp = m_data;
            12'd6:
            begin
                rsp[0] = wr_addr64;
                // Mask byte of the lane that holds the first written byte
                rsp[1] = (m_mask >> {m_byte_idx[5:3], 3'b000}) & 64'hff;
            end
            12'd10:
            begin
                rsp[0] = wr_addr64;
                rsp[1] = m_mask;
            end
            default: rsp = '0;
        endcase
        return rsp;
    endfunction

    // ======================================================================
    // Checks, bus tasks and the read monitor
    // ======================================================================

    task automatic check_value(input logic [511:0] actual, input logic [511:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("Mismatch at %0d ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("Test %s finished with %0d errors", name, error_count - errors_before);
    endtask

    // Called at 1 ns after an edge with the request already driven
    // Returns 1 ns after the edge that accepted it
    task automatic wait_for_accept();
        logic accepted;
        accepted = 1'b0;
        while (!accepted)
        begin
            @(negedge clk);
            accepted = !waitrequest;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic write_request(input mmio_afu_pkg::mmio_addr_t addr,
                                 input mmio_afu_pkg::mmio_data_t data,
                                 input mmio_afu_pkg::mmio_mask_t be);
        address    = addr;
        writedata  = data;
        byteenable = be;
        write      = 1'b1;
        wait_for_accept();
        write = 1'b0;
        model_data     = data;
        model_mask     = be;
        model_addr     = addr;
        model_byte_idx = lowest_enabled_byte(be);
    endtask

    task automatic read_request(input mmio_afu_pkg::mmio_addr_t addr,
                                input mmio_afu_pkg::mmio_mask_t be);
        address    = addr;
        byteenable = be;
        read       = 1'b1;
        wait_for_accept();
        read = 1'b0;
        exp_data_q.push_back(expected_read(addr, be, model_data, model_mask,
                                           model_addr, model_byte_idx));
        exp_cycle_q.push_back(cycle_count + 1);
        read_pending = 1'b1;
        // The beat is due at the next edge, give the monitor one more edge
        @(posedge clk);
        @(posedge clk);
        #1;
        if (read_pending)
        begin
            error_count++;
            $display("Error at %0d ns: no readdatavalid for the read of address %0h",
                     $time, addr);
            exp_data_q.delete();
            exp_cycle_q.delete();
            read_pending = 1'b0;
        end
    endtask

    // Data beats are sampled at the falling edge, where they are stable
    always @(negedge clk)
    begin
        if (readdatavalid)
        begin
            if (exp_data_q.size() == 0)
            begin
                error_count++;
                $display("Error at %0d ns: readdatavalid went high with no read outstanding",
                         $time);
            end
            else
            begin
                mon_data  = exp_data_q.pop_front();
                mon_cycle = exp_cycle_q.pop_front();
                check_value(512'(cycle_count), 512'(mon_cycle), "readdatavalid cycle");
                check_value(readdata, mon_data, "readdata");
                read_pending = 1'b0;
            end
        end
    end

    // Cycle counter and run limit
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial
    begin
        mmio_afu_pkg::mmio_addr_t addr;
        mmio_afu_pkg::mmio_mask_t be;
        int                       errors_before;
        clk            = 1'b0;
        reset_n        = 1'b0;
        address        = '0;
        read           = 1'b0;
        write          = 1'b0;
        writedata      = '0;
        byteenable     = '0;
        lcg_state      = 64'd11;
        read_pending   = 1'b0;
        model_data     = '1;
        model_mask     = '1;
        model_addr     = '1;
        model_byte_idx = '1;

        // Test 1, reset for five edges, then the throttle period
        errors_before = error_count;
        for (int i = 0; i < 5; i++)
        begin
            @(posedge clk);
            #1;
            if (i == 4)
            begin
                reset_n = 1'b1;
            end
            @(negedge clk);
            check_value(512'(waitrequest), 512'(1'b1), "waitrequest in reset");
        end
        // Edge k counts from the first edge that sees reset_n high
        for (int k = 1; k <= 40; k++)
        begin
            @(posedge clk);
            @(negedge clk);
            check_value(512'(waitrequest), 512'((k % 16) != 8), "waitrequest pattern");
            check_value(512'(readdatavalid), 512'(1'b0), "readdatavalid before any read");
        end
        report_test("1 reset and throttle", errors_before);
        @(posedge clk);
        #1;

        // Test 2, identity block with random byte enables
        errors_before = error_count;
        for (int i = 0; i < N_IDENT; i++)
        begin
            read_request(index_addr(12'd0), random_byte_enable());
        end
        report_test("2 identity block", errors_before);

        // Test 3, status word and indexes outside the map
        errors_before = error_count;
        read_request(index_addr(12'd2), random_byte_enable());
        for (int i = 0; i < N_UNMAPPED; i++)
        begin
            read_request(index_addr(unmapped_index()), random_byte_enable());
        end
        report_test("3 status and unmapped", errors_before);

        // Test 4, capture registers still hold their reset value
        errors_before = error_count;
        read_request(index_addr(12'd4), random_byte_enable());
        read_request(index_addr(12'd8), random_byte_enable());
        read_request(index_addr(12'd6), random_byte_enable());
        read_request(index_addr(12'd10), random_byte_enable());
        report_test("4 write state after reset", errors_before);

        // Test 5, random writes, one of them with no byte enabled
        errors_before = error_count;
        for (int i = 0; i < N_WRITES; i++)
        begin
            be   = (i == 2) ? '0 : random_byte_enable();
            addr = mmio_afu_pkg::mmio_addr_t'(lcg_rand32());
            write_request(addr, random_data(), be);
            read_request(index_addr(12'd4), random_byte_enable());
            read_request(index_addr(12'd6), random_byte_enable());
            read_request(index_addr(12'd8), random_byte_enable());
            read_request(index_addr(12'd10), random_byte_enable());
        end
        report_test("5 random writes", errors_before);

        // Test 6, the read is driven right after the write is accepted
        errors_before = error_count;
        for (int i = 0; i < N_B2B; i++)
        begin
            addr = mmio_afu_pkg::mmio_addr_t'(lcg_rand32());
            write_request(addr, random_data(), random_byte_enable());
            read_request(index_addr(12'd10), random_byte_enable());
        end
        report_test("6 back-to-back", errors_before);

        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, dut.u_checker.assert_errors);
        if (error_count == 0 && dut.u_checker.assert_errors == 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- mmio_test_afu.f
+incdir+rtl
rtl/mmio_afu_pkg.sv
rtl/mmio_wait_throttle.sv
rtl/mmio_write_capture.sv
rtl/mmio_read_responder.sv
rtl/mmio_test_afu.sv
testbench/mmio_test_afu_checker.sv
testbench/mmio_test_afu_tb.sv

//--- Makefile
# Verilator build for the MMIO test endpoint
# Every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= mmio_test_afu_tb
FILELIST  ?= mmio_test_afu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --timescale 1ns/1ps --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
	    --Mdir $(OBJ_DIR) -o V$(TOP)

# The run fails when the log reports failure or the binary exits with an error
sim: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "Simulation finished: FAIL" $(LOG); then \
	    echo "sim: the testbench reported failure, see $(LOG)"; \
	    exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
	    echo "sim: simulator exited with status $$status"; \
	    exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
